// ==== hdl/bnet_pkg.sv ====
`default_nettype none

package bnet_pkg;

    // Packet geometry
    localparam int PKT_W     = 38;
    localparam int TAG_W     = 11;
    localparam int DEST_W    = 7;
    // Data field fills what is left below the branch bit
    localparam int DATA_W    = PKT_W - TAG_W - DEST_W - 2;

    // Routing tables, indexed by low dest bits only
    localparam int TBL_IDX_W = 6;
    localparam int TBL_DEPTH = 64;
    localparam int N_TABLES  = 3;
    localparam int N_LEAVES  = 4;

    // AXI4-Lite configuration port
    localparam int AXIL_AW = 8;
    localparam int AXIL_DW = 32;
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // Same bit positions as the reference packet, br sits at bit 18
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DEST_W-1:0] dest;
        logic              spare;
        logic              br;
        logic [DATA_W-1:0] data;
    } bnet_packet_t;

    // Bit i is the next branch bit for low dest bits equal to i
    typedef struct packed {
        logic [TBL_DEPTH-1:0] tbl0;
        logic [TBL_DEPTH-1:0] tbl1;
        logic [TBL_DEPTH-1:0] tbl2;
    } route_tables_t;

    // Master side of the config bus
    typedef struct packed {
        logic [AXIL_AW-1:0]   awaddr;
        logic                 awvalid;
        logic [AXIL_DW-1:0]   wdata;
        logic [AXIL_DW/8-1:0] wstrb;
        logic                 wvalid;
        logic                 bready;
        logic [AXIL_AW-1:0]   araddr;
        logic                 arvalid;
        logic                 rready;
    } axil_req_t;

    // Slave side of the config bus
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic [1:0]         bresp;
        logic               bvalid;
        logic               arready;
        logic [AXIL_DW-1:0] rdata;
        logic [1:0]         rresp;
        logic               rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/branch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_ctrl (
    input  logic CP,
    input  logic MR,
    input  logic send_in,
    output logic ack_out,
    input  logic br,
    output logic send_out_a,
    output logic send_out_b,
    input  logic ack_in_a,
    input  logic ack_in_b,
    output logic load
);

    // Slot occupancy and the side picked at accept time
    logic full_q;
    logic side_b_q;
    logic taken;

    // Held packet leaves when the chosen side acks
    assign taken = full_q && (side_b_q ? ack_in_b : ack_in_a);

    // Empty slot, or one that drains this cycle, can take a new packet
    assign ack_out = !full_q || taken;
    assign load    = send_in && ack_out;

    // One send at a time, on the latched side only
    assign send_out_a = full_q && !side_b_q;
    assign send_out_b = full_q && side_b_q;

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            full_q   <= 1'b0;
            side_b_q <= 1'b0;
        end else begin
            if (load) begin
                full_q   <= 1'b1;
                // br 0 steers to a, br 1 to b
                side_b_q <= br;
            end else if (taken) begin
                full_q <= 1'b0;
            end
        end
    end

    // Stalled send on a must persist
    a_hold_a: assert property (
        @(posedge CP) disable iff (MR)
        send_out_a && !ack_in_a |=> send_out_a
    );

    // Same for side b
    a_hold_b: assert property (
        @(posedge CP) disable iff (MR)
        send_out_b && !ack_in_b |=> send_out_b
    );

endmodule

`default_nettype wire

// ==== hdl/branch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_stage (
    input  logic                           CP,
    input  logic                           MR,
    input  bnet_pkg::bnet_packet_t         pkt_in,
    input  logic                           send_in,
    output logic                           ack_out,
    input  logic [bnet_pkg::TBL_DEPTH-1:0] route_tbl,
    output bnet_pkg::bnet_packet_t         pkt_out,
    output logic                           send_out_a,
    output logic                           send_out_b,
    input  logic                           ack_in_a,
    input  logic                           ack_in_b
);

    logic                           load;
    logic [bnet_pkg::TBL_IDX_W-1:0] tbl_idx;
    logic                           next_br;
    bnet_pkg::bnet_packet_t         pkt_next;
    bnet_pkg::bnet_packet_t         pkt_q;

    // Lookup uses the low six dest bits only
    assign tbl_idx = pkt_in.dest[bnet_pkg::TBL_IDX_W-1:0];
    assign next_br = route_tbl[tbl_idx];

    // Merge the table bit in place of br
    always_comb begin
        pkt_next    = pkt_in;
        pkt_next.br = next_br;
    end

    // Incoming br picks the side before it is overwritten
    branch_ctrl u_ctrl (
        .CP         (CP),
        .MR         (MR),
        .send_in    (send_in),
        .ack_out    (ack_out),
        .br         (pkt_in.br),
        .send_out_a (send_out_a),
        .send_out_b (send_out_b),
        .ack_in_a   (ack_in_a),
        .ack_in_b   (ack_in_b),
        .load       (load)
    );

    // Data latch, shared by both outputs
    always_ff @(posedge CP) begin
        if (load) begin
            pkt_q <= pkt_next;
        end
    end

    assign pkt_out = pkt_q;

    // Held packet may not change while its consumer stalls
    a_pkt_stable: assert property (
        @(posedge CP) disable iff (MR)
        (send_out_a && !ack_in_a) || (send_out_b && !ack_in_b)
            |=> $stable(pkt_out)
    );

endmodule

`default_nettype wire

// ==== hdl/route_table_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_table_regs (
    input  logic                    CP,
    input  logic                    MR,
    input  bnet_pkg::axil_req_t     axil_req,
    output bnet_pkg::axil_rsp_t     axil_rsp,
    output bnet_pkg::route_tables_t tables
);

    // One table per entry, split in two bus words
    logic [bnet_pkg::N_TABLES-1:0][1:0][bnet_pkg::AXIL_DW-1:0] tbl_q;

    logic                         bvalid_q;
    logic                         rvalid_q;
    logic [1:0]                   bresp_q;
    logic [1:0]                   rresp_q;
    logic [bnet_pkg::AXIL_DW-1:0] rdata_q;
    logic                         wr_fire;
    logic                         ar_fire;
    logic                         wr_hit;
    logic                         rd_hit;

    // Word aligned, below 0x18
    function automatic logic addr_hit(input logic [bnet_pkg::AXIL_AW-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr[bnet_pkg::AXIL_AW-1:5] == '0) &&
               (addr[4:3] < bnet_pkg::N_TABLES);
    endfunction

    // AW and W go together, never while a response is pending
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign ar_fire = axil_req.arvalid && !rvalid_q;
    assign wr_hit  = addr_hit(axil_req.awaddr);
    assign rd_hit  = addr_hit(axil_req.araddr);

    // Write strobes are ignored, every write is a full word
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            tbl_q <= '0;
        end else if (wr_fire && wr_hit) begin
            tbl_q[axil_req.awaddr[4:3]][axil_req.awaddr[2]] <= axil_req.wdata;
        end
    end

    // Handshake flags
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge CP) begin
        if (wr_fire) begin
            bresp_q <= wr_hit ? bnet_pkg::RESP_OKAY : bnet_pkg::RESP_SLVERR;
        end
        if (ar_fire) begin
            rresp_q <= rd_hit ? bnet_pkg::RESP_OKAY : bnet_pkg::RESP_SLVERR;
            // Unmapped reads give zero
            rdata_q <= rd_hit ? tbl_q[axil_req.araddr[4:3]][axil_req.araddr[2]] : '0;
        end
    end

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = !rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign axil_rsp.rvalid  = rvalid_q;

    // Tables to the stages, root first
    assign tables.tbl0 = tbl_q[0];
    assign tables.tbl1 = tbl_q[1];
    assign tables.tbl2 = tbl_q[2];

    a_bvalid_hold: assert property (
        @(posedge CP) disable iff (MR)
        bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q)
    );

    a_rvalid_hold: assert property (
        @(posedge CP) disable iff (MR)
        rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q)
    );

endmodule

`default_nettype wire

// ==== hdl/branch_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_tree (
    input  logic                                           CP,
    input  logic                                           MR,
    input  bnet_pkg::axil_req_t                            axil_req,
    output bnet_pkg::axil_rsp_t                            axil_rsp,
    input  bnet_pkg::bnet_packet_t                         pkt_in,
    input  logic                                           send_in,
    output logic                                           ack_out,
    output bnet_pkg::bnet_packet_t [bnet_pkg::N_LEAVES-1:0] pkt_out,
    output logic [bnet_pkg::N_LEAVES-1:0]                  send_out,
    input  logic [bnet_pkg::N_LEAVES-1:0]                  ack_in
);

    bnet_pkg::route_tables_t tables;
    // Root to second level
    bnet_pkg::bnet_packet_t  root_pkt;
    logic                    root_send_a;
    logic                    root_send_b;
    logic                    a_ack;
    logic                    b_ack;
    // Second level registers
    bnet_pkg::bnet_packet_t  a_pkt;
    bnet_pkg::bnet_packet_t  b_pkt;

    route_table_regs u_regs (
        .CP (CP), .MR (MR),
        .axil_req (axil_req), .axil_rsp (axil_rsp), .tables (tables)
    );

    branch_stage stage_root (
        .CP (CP), .MR (MR),
        .pkt_in (pkt_in), .send_in (send_in), .ack_out (ack_out),
        .route_tbl (tables.tbl0), .pkt_out (root_pkt),
        .send_out_a (root_send_a), .send_out_b (root_send_b),
        .ack_in_a (a_ack), .ack_in_b (b_ack)
    );

    // Leaves 0 and 1
    branch_stage stage_a (
        .CP (CP), .MR (MR),
        .pkt_in (root_pkt), .send_in (root_send_a), .ack_out (a_ack),
        .route_tbl (tables.tbl1), .pkt_out (a_pkt),
        .send_out_a (send_out[0]), .send_out_b (send_out[1]),
        .ack_in_a (ack_in[0]), .ack_in_b (ack_in[1])
    );

    // Leaves 2 and 3
    branch_stage stage_b (
        .CP (CP), .MR (MR),
        .pkt_in (root_pkt), .send_in (root_send_b), .ack_out (b_ack),
        .route_tbl (tables.tbl2), .pkt_out (b_pkt),
        .send_out_a (send_out[2]), .send_out_b (send_out[3]),
        .ack_in_a (ack_in[2]), .ack_in_b (ack_in[3])
    );

    // Leaf pairs share one register, send_out marks the owner
    assign pkt_out[0] = a_pkt;
    assign pkt_out[1] = a_pkt;
    assign pkt_out[2] = b_pkt;
    assign pkt_out[3] = b_pkt;

endmodule

`default_nettype wire

// ==== test/tb_branch_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_tree;

    // Config and traffic take about this many cycles
    localparam int PLANNED_CYCLES = 700;
    localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;

    // Expected leaf and leaf packet for one input packet
    typedef struct packed {
        logic [1:0]             leaf;
        bnet_pkg::bnet_packet_t pkt;
    } route_result_t;

    logic                                            CP = 1'b0;
    logic                                            MR;
    bnet_pkg::axil_req_t                             axil_req;
    bnet_pkg::axil_rsp_t                             axil_rsp;
    bnet_pkg::bnet_packet_t                          pkt_in;
    logic                                            send_in;
    logic                                            ack_out;
    bnet_pkg::bnet_packet_t [bnet_pkg::N_LEAVES-1:0] pkt_out;
    logic [bnet_pkg::N_LEAVES-1:0]                   send_out;
    logic [bnet_pkg::N_LEAVES-1:0]                   ack_in = '1;

    bnet_pkg::route_tables_t shadow = '0;
    bnet_pkg::bnet_packet_t  exp_q [bnet_pkg::N_LEAVES][$];
    bnet_pkg::bnet_packet_t  held_pkt [bnet_pkg::N_LEAVES];
    logic [bnet_pkg::N_LEAVES-1:0] held_valid = '0;
    integer seed;
    integer stall_seed;
    logic   stall_en = 1'b0;
    int     cycles = 0;

    branch_tree uut (
        .CP (CP), .MR (MR),
        .axil_req (axil_req), .axil_rsp (axil_rsp),
        .pkt_in (pkt_in), .send_in (send_in), .ack_out (ack_out),
        .pkt_out (pkt_out), .send_out (send_out), .ack_in (ack_in)
    );

    always #50 CP = ~CP;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_packet(input string name, input bnet_pkg::bnet_packet_t exp,
                                input bnet_pkg::bnet_packet_t act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_rdata(input logic [bnet_pkg::AXIL_DW-1:0] exp,
                               input logic [bnet_pkg::AXIL_DW-1:0] act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] rdata expected %h got %h", exp, act));
    endtask

    task automatic check_resp(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] resp expected %h got %h", exp, act));
    endtask

    // Root bit picks leaf within the pair, leaf stage table gives the new br
    function automatic route_result_t route_ref(input bnet_pkg::bnet_packet_t p,
                                                input bnet_pkg::route_tables_t t);
        route_result_t                  r;
        logic [bnet_pkg::TBL_IDX_W-1:0] idx;
        idx    = p.dest[bnet_pkg::TBL_IDX_W-1:0];
        r.leaf = {p.br, t.tbl0[idx]};
        r.pkt  = p;
        r.pkt.br = p.br ? t.tbl2[idx] : t.tbl1[idx];
        return r;
    endfunction

    // Word w is table w/2, half w%2, low half first
    function automatic logic [31:0] shadow_word(input int w);
        logic [bnet_pkg::TBL_DEPTH-1:0] t;
        case (w / 2)
            0:       t = shadow.tbl0;
            1:       t = shadow.tbl1;
            default: t = shadow.tbl2;
        endcase
        return t[32*(w%2) +: 32];
    endfunction

    function automatic int total_pending();
        int n;
        n = 0;
        for (int i = 0; i < bnet_pkg::N_LEAVES; i++)
            n += exp_q[i].size();
        return n;
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge CP);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        do @(posedge CP); while (!(axil_rsp.awready && axil_rsp.wready));
        @(negedge CP);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        // bready is held high, response taken at first bvalid edge
        do @(posedge CP); while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge CP);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        do @(posedge CP); while (!axil_rsp.arready);
        @(negedge CP);
        axil_req.arvalid = 1'b0;
        do @(posedge CP); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
    endtask

    // Write one table word and mirror it
    task automatic set_word(input int w, input logic [31:0] d);
        logic [1:0] resp;
        write_reg({3'b000, w[2:0], 2'b00}, d, resp);
        check_resp(bnet_pkg::RESP_OKAY, resp);
        case (w / 2)
            0:       shadow.tbl0[32*(w%2) +: 32] = d;
            1:       shadow.tbl1[32*(w%2) +: 32] = d;
            default: shadow.tbl2[32*(w%2) +: 32] = d;
        endcase
    endtask

    task automatic verify_words();
        logic [31:0] d;
        logic [1:0]  resp;
        for (int w = 0; w < 6; w++) begin
            read_reg({3'b000, w[2:0], 2'b00}, d, resp);
            check_resp(bnet_pkg::RESP_OKAY, resp);
            check_rdata(shadow_word(w), d);
        end
    endtask

    // Held until the root acks, then queued on its predicted leaf
    task automatic send_packet(input bnet_pkg::bnet_packet_t p);
        route_result_t r;
        @(negedge CP);
        pkt_in  = p;
        send_in = 1'b1;
        do @(posedge CP); while (!ack_out);
        r = route_ref(p, shadow);
        exp_q[r.leaf].push_back(r.pkt);
    endtask

    task automatic run_traffic(input int n, input logic stall);
        logic [31:0] hi;
        logic [31:0] lo;
        stall_en = stall;
        for (int i = 0; i < n; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            send_packet({hi[5:0], lo});
        end
        @(negedge CP);
        send_in = 1'b0;
        // Drain before anything else touches the tables
        while (total_pending() != 0)
            @(posedge CP);
        stall_en = 1'b0;
    endtask

    // Random leaf back-pressure, each ack high about 3 cycles in 4
    always @(negedge CP) begin
        logic [31:0] r;
        if (stall_en) begin
            r      = $random(stall_seed);
            ack_in = r[3:0] | r[7:4];
        end else begin
            ack_in = '1;
        end
    end

    // Leaf monitor, order per leaf and stability under stall
    always @(posedge CP) begin
        bnet_pkg::bnet_packet_t exp;
        for (int i = 0; i < bnet_pkg::N_LEAVES; i++) begin
            if (held_valid[i])
                check_packet($sformatf("pkt_out[%0d]", i), held_pkt[i], pkt_out[i]);
            if (send_out[i] && ack_in[i]) begin
                held_valid[i] = 1'b0;
                if (exp_q[i].size() == 0) begin
                    report_failure($sformatf("leaf %0d delivered a packet nobody sent", i));
                end else begin
                    exp = exp_q[i].pop_front();
                    check_packet($sformatf("pkt_out[%0d]", i), exp, pkt_out[i]);
                end
            end else begin
                held_valid[i] = send_out[i];
                held_pkt[i]   = pkt_out[i];
            end
        end
    end

    always @(posedge CP) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            report_failure($sformatf("timeout after %0d cycles, run did not finish", cycles));
    end

    initial begin
        logic [31:0] d;
        logic [1:0]  resp;
        seed            = 42;
        stall_seed      = $random(seed);
        MR              = 1'b1;
        axil_req        = '0;
        axil_req.wstrb  = '1;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        pkt_in          = '0;
        send_in         = 1'b0;
        repeat (5) @(negedge CP);
        MR = 1'b0;

        // Tables clear after reset, no leaf active
        verify_words();
        if (send_out !== '0)
            report_failure("a leaf send is high right after reset");

        // Random table contents, then read back
        for (int w = 0; w < 6; w++)
            set_word(w, $random(seed));
        verify_words();

        // Unmapped word
        write_reg(8'h18, $random(seed), resp);
        check_resp(bnet_pkg::RESP_SLVERR, resp);
        read_reg(8'h18, d, resp);
        check_resp(bnet_pkg::RESP_SLVERR, resp);
        check_rdata('0, d);
        verify_words();

        // Free flowing, then stalled leaves
        run_traffic(200, 1'b0);
        run_traffic(200, 1'b1);

        // New root and tbl2 words after drain
        set_word(0, ~shadow_word(0));
        set_word(5, ~shadow_word(5));
        run_traffic(60, 1'b0);

        // Every leaf idle once the last expected packet has left
        @(negedge CP);
        if (send_out !== '0) begin
            report_failure("a leaf still sends after every expected packet arrived");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/bnet_pkg.sv
hdl/branch_ctrl.sv
hdl/branch_stage.sv
hdl/route_table_regs.sv
hdl/branch_tree.sv
test/tb_branch_tree.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the branch tree testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branch_tree -f list.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation run returned an error status"; exit 1; }
